/* compile.f */
+incdir+rtl
rtl/stream_pkg.sv
rtl/stream_fifo.sv
rtl/stream_fence.sv
rtl/stream_slice.sv
rtl/wide_stream_join.sv
testbench/tb_wide_stream_join.sv

/* Bender.yml */
package:
  name: wide_stream_join

export_include_dirs:
  - rtl

sources:
  # design, package first
  - include_dirs:
      - rtl
    files:
      - rtl/stream_pkg.sv
      - rtl/stream_fifo.sv
      - rtl/stream_fence.sv
      - rtl/stream_slice.sv
      - rtl/wide_stream_join.sv

  # testbench
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/tb_wide_stream_join.sv

/* testbench/join_patterns.txt */
// columns are lane 0 to 3 data, then lane 0 to 3 strobes
// then expected wide data and wide strobe, then a clear marker where 1 drops the line
0a1b2c3d 4e5f6071 8293a4b5 c6d7e8f9 f f f f c6d7e8f98293a4b54e5f60710a1b2c3d ffff 0
00000001 00000002 00000003 00000004 1 3 7 f 00000004000000030000000200000001 f731 0
deadbeef cafef00d 12345678 9abcdef0 f f f f 9abcdef012345678cafef00ddeadbeef ffff 0
ffffffff 00000000 ffffffff 00000000 8 4 2 1 00000000ffffffff00000000ffffffff 1248 0
13579bdf 2468ace0 fdb97531 0eca8642 c 3 f 0 0eca8642fdb975312468ace013579bdf 0f3c 0
a5a5a5a5 5a5a5a5a 3c3c3c3c c3c3c3c3 f e d b c3c3c3c33c3c3c3c5a5a5a5aa5a5a5a5 bdef 0
76543210 fedcba98 01234567 89abcdef f f 0 f 89abcdef01234567fedcba9876543210 f0ff 0
11223344 55667788 99aabbcc ddeeff00 3 c 3 c ddeeff0099aabbcc5566778811223344 c3c3 0
bad0bad0 bad1bad1 bad2bad2 bad3bad3 f f f f bad3bad3bad2bad2bad1bad1bad0bad0 ffff 1
80000000 40000000 20000000 10000000 8 4 2 1 10000000200000004000000080000000 1248 0
0000ffff ffff0000 00ff00ff ff00ff00 3 c 5 a ff00ff0000ff00ffffff00000000ffff a5c3 0
31415926 53589793 23846264 33832795 f f f f 33832795238462645358979331415926 ffff 0
27182818 28459045 23536028 74713526 7 b d e 74713526235360282845904527182818 edb7 0
0f0f0f0f f0f0f0f0 00000000 ffffffff f 0 f 0 ffffffff00000000f0f0f0f00f0f0f0f 0f0f 0
12121212 34343434 56565656 78787878 1 1 1 1 78787878565656563434343412121212 1111 0
9e3779b9 7f4a7c15 f39cc060 5ced1a2b f f f f 5ced1a2bf39cc0607f4a7c159e3779b9 ffff 0
bad4bad4 bad5bad5 bad6bad6 bad7bad7 f f f f bad7bad7bad6bad6bad5bad5bad4bad4 ffff 1
00000010 00000020 00000030 00000040 f f f f 00000040000000300000002000000010 ffff 0
aaaaaaaa bbbbbbbb cccccccc dddddddd 6 9 6 9 ddddddddccccccccbbbbbbbbaaaaaaaa 9696 0
01010101 02020202 04040404 08080808 2 4 8 1 08080808040404040202020201010101 1842 0
c0ffee00 beefcafe 0badf00d feedface f f f f feedface0badf00dbeefcafec0ffee00 ffff 0
7fffffff 80000001 7ffffffe 80000002 e 7 f 1 800000027ffffffe800000017fffffff 1f7e 0
00c0ffee 11d00d11 22e00e22 33f00f33 f 8 f 8 33f00f3322e00e2211d00d1100c0ffee 8f8f 0
6a09e667 bb67ae85 3c6ef372 a54ff53a f f f f a54ff53a3c6ef372bb67ae856a09e667 ffff 0
510e527f 9b05688c 1f83d9ab 5be0cd19 3 f c f 5be0cd191f83d9ab9b05688c510e527f fcf3 0
5a5a0000 0000a5a5 ffff0000 0000ffff f f f f 0000ffffffff00000000a5a55a5a0000 ffff 0

/* testbench/tb_wide_stream_join.sv */
// ====================
// self-checking testbench of the wide stream joiner that runs from the project root
// reads testbench/join_patterns.txt, laid out for 4 lanes of 32 bits
// ====================

`timescale 1ns/10ps

`include "stream_cfg.svh"

module tb_wide_stream_join;

  localparam int NB           = `NB_STREAMS;
  localparam int NUM_PATTERNS = 26;
  // lane words, lane strobes, wide data, wide strobe, clear marker
  localparam int WORDS        = 2 * NB + 3;
  localparam int NUM_PHASES   = 3;
  localparam int RESET_CYCLES = 3;
  localparam int CLEAR_CYCLES = 16;
  localparam int DRAIN_CYCLES = 8;
  localparam logic [31:0] SEED = 32'h7646_bf0d;

  logic                   clk;
  logic                   rst_n;
  logic                   clear;
  logic [NB-1:0]          lane_valid;
  stream_pkg::lane_data_t lane_data [NB];
  stream_pkg::lane_strb_t lane_strb [NB];
  logic [NB-1:0]          lane_ready;
  logic                   out_valid;
  stream_pkg::wide_data_t out_data;
  stream_pkg::wide_strb_t out_strb;
  logic                   out_ready;

  // pattern table with one row of WORDS entries per line
  logic [NB*`DATA_WIDTH-1:0] pat_mem [NUM_PATTERNS*WORDS];

  // ====================
  // run control
  // ====================

  logic [NB-1:0] lane_go = '0;
  logic [31:0]   lane_rng [NB];
  logic          gap_en;
  logic          bp_en;
  int            phase;
  int            seg_first;
  int            seg_end;
  int            target;
  int            out_count;
  int            cycle_count;
  int            timeout_limit;
  // pattern indices still expected at the output in order
  int            exp_q [$];

  wide_stream_join wide_stream_join_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .clear_i      (clear),
    .lane_valid_i (lane_valid),
    .lane_data_i  (lane_data),
    .lane_strb_i  (lane_strb),
    .lane_ready_o (lane_ready),
    .out_valid_o  (out_valid),
    .out_data_o   (out_data),
    .out_strb_o   (out_strb),
    .out_ready_i  (out_ready)
  );

  // ====================
  // helpers
  // ====================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic stream_pkg::lane_data_t lane_word(input int n, input int lane);
    return pat_mem[n*WORDS + lane][`DATA_WIDTH-1:0];
  endfunction

  function automatic stream_pkg::lane_strb_t lane_strobe(input int n, input int lane);
    return pat_mem[n*WORDS + NB + lane][`STRB_WIDTH-1:0];
  endfunction

  function automatic stream_pkg::wide_data_t exp_wide_data(input int n);
    return pat_mem[n*WORDS + 2*NB];
  endfunction

  function automatic stream_pkg::wide_strb_t exp_wide_strb(input int n);
    return pat_mem[n*WORDS + 2*NB + 1][NB*`STRB_WIDTH-1:0];
  endfunction

  function automatic logic is_clear(input int n);
    return pat_mem[n*WORDS + 2*NB + 2][0];
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(input string name, input stream_pkg::wide_data_t exp,
                            input stream_pkg::wide_data_t act);
    if (act !== exp)
      stop_with_failure($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_strb(input string name, input stream_pkg::wide_strb_t exp,
                            input stream_pkg::wide_strb_t act);
    if (act !== exp)
      stop_with_failure($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp)
      stop_with_failure($sformatf("FAIL %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // walks lines seg_first up to seg_end on one lane with random gaps
  task automatic drive_lane(input int lane);
    int   idx;
    logic hold;
    logic done;
    idx  = seg_first;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      // a presented beat that was not taken must stay
      hold = lane_valid[lane] & ~lane_ready[lane];
      if (lane_valid[lane] && lane_ready[lane])
        idx++;
      #1;
      if (!hold)
      begin
        lane_rng[lane] = xorshift32(lane_rng[lane]);
        if (idx >= seg_end)
        begin
          lane_valid[lane] = 1'b0;
          done = 1'b1;
        end
        else if (gap_en && lane_rng[lane][2:0] < 3'd3)
          lane_valid[lane] = 1'b0;
        else
        begin
          lane_valid[lane] = 1'b1;
          lane_data[lane]  = lane_word(idx, lane);
          lane_strb[lane]  = lane_strobe(idx, lane);
        end
      end
    end
  endtask

  // lane 0 alone must not release a beat and the clear drops it
  task automatic drop_partial(input int n);
    @(posedge clk);
    #1;
    lane_valid[0] = 1'b1;
    lane_data[0]  = lane_word(n, 0);
    lane_strb[0]  = lane_strobe(n, 0);
    @(posedge clk);
    while (!lane_ready[0])
      @(posedge clk);
    #1;
    lane_valid[0] = 1'b0;
    repeat (10)
    begin
      @(posedge clk);
      if (out_valid !== 1'b0)
        stop_with_failure($sformatf("output went valid with only lane 0 of line %0d", n));
    end
    #1;
    clear = 1'b1;
    @(posedge clk);
    #1;
    clear = 1'b0;
  endtask

  // ====================
  // clock, drivers, monitor
  // ====================

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  for (genvar g = 0; g < NB; g++)
  begin : gen_driver
    initial
    begin
      forever
      begin
        wait (lane_go[g]);
        drive_lane(g);
        lane_go[g] = 1'b0;
      end
    end
  end

  // sink side stalls at random only in the back-pressure phase
  initial
  begin : ready_driver
    logic [31:0] rng;
    rng = SEED;
    forever
    begin
      @(posedge clk);
      #1;
      rng = xorshift32(rng);
      out_ready = ~bp_en | (rng[1:0] != 2'b00);
    end
  end

  always @(posedge clk)
  begin : monitor
    int n;
    if (rst_n && out_valid && out_ready)
    begin
      // every accepted beat counts even with no line left to match
      out_count++;
      if (exp_q.size() != 0)
      begin
        n = exp_q.pop_front();
        check_data($sformatf("phase %0d line %0d data", phase, n), exp_wide_data(n), out_data);
        check_strb($sformatf("phase %0d line %0d strb", phase, n), exp_wide_strb(n), out_strb);
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count > timeout_limit)
      stop_with_failure($sformatf("the run did not finish within %0d cycles", timeout_limit));
  end

  // ====================
  // main sequence
  // ====================

  initial
  begin : main_seq
    int n;
    int first;
    int clears;
    rst_n       = 1'b0;
    clear       = 1'b0;
    lane_valid  = '0;
    out_ready   = 1'b1;
    gap_en      = 1'b0;
    bp_en       = 1'b0;
    phase       = 0;
    target      = 0;
    out_count   = 0;
    cycle_count = 0;
    for (int i = 0; i < NB; i++)
    begin
      lane_data[i] = '0;
      lane_strb[i] = '0;
      lane_rng[i]  = SEED ^ (32'h9e37_79b9 * (i + 1));
    end

    $readmemh("testbench/join_patterns.txt", pat_mem);
    if ($isunknown(pat_mem[NUM_PATTERNS*WORDS-1]))
      stop_with_failure("the pattern file is missing or shorter than expected");
    clears = 0;
    for (int i = 0; i < NUM_PATTERNS; i++)
      if (is_clear(i))
        clears++;
    timeout_limit = NUM_PHASES * (20 * NUM_PATTERNS + clears * CLEAR_CYCLES + DRAIN_CYCLES)
                    + RESET_CYCLES + 2;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    check_count("reset out_valid_o", 0, int'(out_valid));
    check_count("reset lane_ready_o", (1 << NB) - 1, int'(lane_ready));

    // in step, then skewed lanes, then skew with back-pressure
    for (int p = 0; p < NUM_PHASES; p++)
    begin
      phase  = p;
      gap_en = (p >= 1);
      bp_en  = (p >= 2);
      n = 0;
      while (n < NUM_PATTERNS)
      begin
        first = n;
        while (n < NUM_PATTERNS && !is_clear(n))
        begin
          exp_q.push_back(n);
          n++;
        end
        if (n > first)
        begin
          seg_first = first;
          seg_end   = n;
          target    = target + (n - first);
          lane_go   = '1;
          wait (lane_go == '0);
          wait (out_count >= target);
        end
        if (n < NUM_PATTERNS)
        begin
          drop_partial(n);
          n++;
        end
      end
      // late or repeated beats would still show up here
      repeat (DRAIN_CYCLES) @(posedge clk);
      check_count($sformatf("phase %0d beat count", p), target, out_count);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* rtl/wide_stream_join.sv */
// ====================
// joins NB_STREAMS skewed lanes into one wide stream
// lane FIFOs, then the fence, then one output register stage
// output comes at least two cycles after the last lane is taken
// ====================

`timescale 1ns/10ps

`include "stream_cfg.svh"

module wide_stream_join (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  // narrow lanes
  input  logic [`NB_STREAMS-1:0] lane_valid_i,
  input  stream_pkg::lane_data_t lane_data_i [`NB_STREAMS],
  input  stream_pkg::lane_strb_t lane_strb_i [`NB_STREAMS],
  output logic [`NB_STREAMS-1:0] lane_ready_o,
  // joined stream
  output logic                   out_valid_o,
  output stream_pkg::wide_data_t out_data_o,
  output stream_pkg::wide_strb_t out_strb_o,
  input  logic                   out_ready_i
);

  // ====================
  // internal wires
  // ====================

  // FIFO to fence
  logic [`NB_STREAMS-1:0] fifo_valid;
  stream_pkg::lane_data_t fifo_data [`NB_STREAMS];
  stream_pkg::lane_strb_t fifo_strb [`NB_STREAMS];
  logic [`NB_STREAMS-1:0] fifo_ready;

  // fence to slice, one valid per lane but always equal
  logic [`NB_STREAMS-1:0] fence_valid;
  stream_pkg::lane_data_t fence_data [`NB_STREAMS];
  stream_pkg::lane_strb_t fence_strb [`NB_STREAMS];

  // joined beat
  stream_pkg::wide_data_t join_data;
  stream_pkg::wide_strb_t join_strb;
  logic                   slice_ready;

  // ====================
  // lane FIFOs and concatenation
  // ====================

  for (genvar i = 0; i < `NB_STREAMS; i++)
  begin : gen_lane
    stream_fifo stream_fifo_inst (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .clear_i      (clear_i),
      .push_valid_i (lane_valid_i[i]),
      .push_data_i  (lane_data_i[i]),
      .push_strb_i  (lane_strb_i[i]),
      .push_ready_o (lane_ready_o[i]),
      .pop_valid_o  (fifo_valid[i]),
      .pop_data_o   (fifo_data[i]),
      .pop_strb_o   (fifo_strb[i]),
      .pop_ready_i  (fifo_ready[i])
    );

    // lane 0 lands in the low bits
    assign join_data[i*`DATA_WIDTH +: `DATA_WIDTH] = fence_data[i];
    assign join_strb[i*`STRB_WIDTH +: `STRB_WIDTH] = fence_strb[i];
  end

  stream_fence stream_fence_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .push_valid_i (fifo_valid),
    .push_data_i  (fifo_data),
    .push_strb_i  (fifo_strb),
    .push_ready_o (fifo_ready),
    .pop_valid_o  (fence_valid),
    .pop_data_o   (fence_data),
    .pop_strb_o   (fence_strb),
    // slice ready fans out to every lane
    .pop_ready_i  ({`NB_STREAMS{slice_ready}})
  );

  // lane 0 valid stands for the whole joined beat
  stream_slice stream_slice_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_valid_i  (fence_valid[0]),
    .in_data_i   (join_data),
    .in_strb_i   (join_strb),
    .in_ready_o  (slice_ready),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_strb_o  (out_strb_o),
    .out_ready_i (out_ready_i)
  );

endmodule

/* rtl/stream_slice.sv */
// ====================
// one register stage on the wide stream, full throughput
// cuts the combinational path from the fence to the outside
// ====================

`timescale 1ns/10ps

module stream_slice (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  // from the fence
  input  logic                   in_valid_i,
  input  stream_pkg::wide_data_t in_data_i,
  input  stream_pkg::wide_strb_t in_strb_i,
  output logic                   in_ready_o,
  // to the outside
  output logic                   out_valid_o,
  output stream_pkg::wide_data_t out_data_o,
  output stream_pkg::wide_strb_t out_strb_o,
  input  logic                   out_ready_i
);

  logic                   valid_q;
  stream_pkg::wide_data_t data_q;
  stream_pkg::wide_strb_t strb_q;

  logic load;

  // ====================
  // handshake
  // ====================

  // room when empty or when the held beat leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  // ====================
  // register stage
  // ====================

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid_q <= 1'b0;
    else if (clear_i)
      valid_q <= 1'b0;
    else if (in_ready_o)
      // refill or drain in the same edge
      valid_q <= in_valid_i;
  end

  // payload follows the valid bit
  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      data_q <= in_data_i;
      strb_q <= in_strb_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;
  assign out_strb_o  = strb_q;

endmodule

/* rtl/stream_fence.sv */
// ====================
// lets the beats of all lanes leave together
// combinational from input to output, lane readies must all be the same
// early lanes are latched and held until the joined beat leaves
// ====================

`timescale 1ns/10ps

`include "stream_cfg.svh"

module stream_fence (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  // lanes coming in
  input  logic [`NB_STREAMS-1:0] push_valid_i,
  input  stream_pkg::lane_data_t push_data_i [`NB_STREAMS],
  input  stream_pkg::lane_strb_t push_strb_i [`NB_STREAMS],
  output logic [`NB_STREAMS-1:0] push_ready_o,
  // lanes going out, valid is shared
  output logic [`NB_STREAMS-1:0] pop_valid_o,
  output stream_pkg::lane_data_t pop_data_o  [`NB_STREAMS],
  output stream_pkg::lane_strb_t pop_strb_o  [`NB_STREAMS],
  input  logic [`NB_STREAMS-1:0] pop_ready_i
);

  // one bit per lane that has already handed over its beat
  logic [`NB_STREAMS-1:0] mask_q;
  logic [`NB_STREAMS-1:0] mask_d;

  // latched copies of early beats
  stream_pkg::lane_data_t data_q [`NB_STREAMS];
  stream_pkg::lane_strb_t strb_q [`NB_STREAMS];

  logic all_here;
  logic pop_ready;
  logic release_beat;

  // ====================
  // fence condition
  // ====================

  // every lane is either live or latched
  assign all_here     = &(push_valid_i | mask_q);
  assign pop_ready    = &pop_ready_i;
  assign release_beat = all_here & pop_ready;

  always_comb
  begin
    mask_d = mask_q;
    if (all_here)
    begin
      // joined beat stays put under back-pressure
      if (pop_ready)
        mask_d = '0;
    end
    else
    begin
      // arriving lanes join the mask
      mask_d = mask_q | push_valid_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      mask_q <= '0;
    else if (clear_i)
      mask_q <= '0;
    else
      mask_q <= mask_d;
  end

  // ====================
  // per-lane paths
  // ====================

  for (genvar i = 0; i < `NB_STREAMS; i++)
  begin : gen_lane
    // a latched lane waits, a live lane is taken into the mask
    // or leaves with the joined beat
    assign push_ready_o[i] = ~mask_q[i] & (all_here ? release_beat : 1'b1);

    assign pop_valid_o[i] = all_here;
    // latched copy wins over the live input
    assign pop_data_o[i]  = mask_q[i] ? data_q[i] : push_data_i[i];
    assign pop_strb_o[i]  = mask_q[i] ? strb_q[i] : push_strb_i[i];

    // capture an early beat on its way into the mask
    always_ff @(posedge clk_i)
    begin
      if (push_valid_i[i] && !mask_q[i] && !all_here)
      begin
        data_q[i] <= push_data_i[i];
        strb_q[i] <= push_strb_i[i];
      end
    end
  end

endmodule

/* rtl/stream_fifo.sv */
// ====================
// per-lane valid/ready FIFO, registered output, no fall-through
// a push and a pop may happen in the same cycle
// ====================

`timescale 1ns/10ps

`include "stream_cfg.svh"

module stream_fifo (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  // write side
  input  logic                   push_valid_i,
  input  stream_pkg::lane_data_t push_data_i,
  input  stream_pkg::lane_strb_t push_strb_i,
  output logic                   push_ready_o,
  // read side
  output logic                   pop_valid_o,
  output stream_pkg::lane_data_t pop_data_o,
  output stream_pkg::lane_strb_t pop_strb_o,
  input  logic                   pop_ready_i
);

  localparam int unsigned DEPTH = `FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = PTR_W + 1;

  // entry storage of lane words and strobes
  stream_pkg::lane_data_t data_mem [DEPTH];
  stream_pkg::lane_strb_t strb_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic push_fire;
  logic pop_fire;

  // ====================
  // handshake
  // ====================

  // ready while at least one free entry
  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  // valid while anything is stored
  assign pop_valid_o  = (count_q != '0);

  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_valid_o & pop_ready_i;

  // head of the queue is read straight from the storage
  assign pop_data_o = data_mem[rd_ptr_q];
  assign pop_strb_o = strb_mem[rd_ptr_q];

  // ====================
  // pointers and fill count
  // ====================

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (clear_i)
    begin
      // drop everything buffered
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      // pointers wrap by themselves since the depth is a power of two
      if (push_fire)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_fire)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // count moves only when one side is active alone
      if (push_fire && !pop_fire)
        count_q <= count_q + 1'b1;
      else if (pop_fire && !push_fire)
        count_q <= count_q - 1'b1;
    end
  end

  // write port
  always_ff @(posedge clk_i)
  begin
    if (push_fire)
    begin
      data_mem[wr_ptr_q] <= push_data_i;
      strb_mem[wr_ptr_q] <= push_strb_i;
    end
  end

endmodule

/* rtl/stream_pkg.sv */
// ====================
// data and strobe types of the lanes and of the joined stream
// lane 0 sits in the low bits of the wide types
// ====================

`include "stream_cfg.svh"

package stream_pkg;

  // ====================
  // narrow lane types
  // ====================

  // one lane word
  typedef logic [`DATA_WIDTH-1:0] lane_data_t;

  // byte strobes of one lane word
  typedef logic [`STRB_WIDTH-1:0] lane_strb_t;

  // ====================
  // joined stream types
  // ====================

  // all lanes side by side
  typedef logic [`NB_STREAMS*`DATA_WIDTH-1:0] wide_data_t;
  typedef logic [`NB_STREAMS*`STRB_WIDTH-1:0] wide_strb_t;

endpackage

/* rtl/stream_cfg.svh */
// ====================
// build-time settings of the wide stream joiner
// FIFO_DEPTH must be a power of two and at least 2
// DATA_WIDTH must be a multiple of 8, one strobe per byte
// ====================

`ifndef STREAM_CFG_SVH
`define STREAM_CFG_SVH

// number of narrow lanes that are joined
`define NB_STREAMS 4

// width of one lane in bits
`define DATA_WIDTH 32

// entries in each lane FIFO
`define FIFO_DEPTH 4

// byte strobes per lane
`define STRB_WIDTH (`DATA_WIDTH / 8)

`endif
